/* logic/cam_pkg.sv */
// Widths, sample and coordinate types, APB register map, reset values, frame word union
package cam_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int raw_w       = 12;  // Camera sample
  localparam int coord_w     = 12;  // Column / row counters
  localparam int chan_w      = 8;   // Output colour channel
  localparam int field_w     = 5;   // Colour field in frame word
  localparam int bin_w       = 8;   // Binarized byte
  localparam int frame_cnt_w = 32;
  localparam int apb_addr_w  = 8;
  localparam int apb_data_w  = 32;

  typedef logic [raw_w-1:0]   raw_t;
  typedef logic [coord_w-1:0] coord_t;
  typedef logic [chan_w-1:0]  chan_t;

  // ==================================================
  // Register map
  // ==================================================
  localparam logic [apb_addr_w-1:0] addr_ctrl   = 8'h00;
  localparam logic [apb_addr_w-1:0] addr_width  = 8'h04;
  localparam logic [apb_addr_w-1:0] addr_height = 8'h08;
  localparam logic [apb_addr_w-1:0] addr_thresh = 8'h0C;
  localparam logic [apb_addr_w-1:0] addr_frames = 8'h10;  // Read only

  // Control register bit positions
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_bin_bit   = 1;
  localparam int ctrl_red_bit   = 4;
  localparam int ctrl_green_bit = 5;
  localparam int ctrl_blue_bit  = 6;

  localparam logic [apb_data_w-1:0] ctrl_rst   = '0;
  localparam coord_t                width_rst  = 12'd640;
  localparam coord_t                height_rst = 12'd480;
  localparam logic [bin_w-1:0]      thresh_rst = 8'd60;

  // ==================================================
  // Frame buffer word, colour or binary view
  // ==================================================
  typedef union packed {
    struct packed {
      logic               pad;    // Always zero
      logic [field_w-1:0] red;
      logic [field_w-1:0] green;
      logic [field_w-1:0] blue;
    } rgb;
    struct packed {
      logic [bin_w-1:0] zero;     // Upper byte unused
      logic [bin_w-1:0] value;    // 255 or 0
    } bin;
  } frame_word_t;

endpackage

/* logic/cam_ifs.sv */
// Pixel stream interface (type parameterized) and configuration interface
`timescale 1ns/1ns

// ==================================================
// Pixel stream, one-cycle valid, no back-pressure
// ==================================================
interface pixel_if import cam_pkg::*; #(
  parameter type data_t = raw_t  // raw_t after capture, frame_word_t after packing
) ();
  data_t  data;
  logic   valid;  // Single pixel strobe
  coord_t col;
  coord_t row;

  modport src (
    output data,
    output valid,
    output col,
    output row
  );
  modport snk (
    input data,
    input valid,
    input col,
    input row
  );
endinterface

// ==================================================
// Configuration from the register block
// ==================================================
interface cfg_if import cam_pkg::*; ();
  logic             start;        // Capture request
  logic             binary_mode;  // 1: binarized byte, 0: 5-5-5 colour
  logic             red_en;
  logic             green_en;
  logic             blue_en;
  coord_t           width;        // Window size in pixels
  coord_t           height;       // Window size in lines
  logic [bin_w-1:0] threshold;    // Compared to raw[11:4]

  // Driver side
  modport regs (output start, output binary_mode, output red_en, output green_en,
                output blue_en, output width, output height, output threshold);
  // Readers along the pixel path
  modport usr (input start, input binary_mode, input red_en, input green_en,
               input blue_en, input width, input height, input threshold);
endinterface

/* logic/cam_apb_regs.sv */
// APB slave with control, window, threshold registers and frame count readback
`timescale 1ns/1ns

module cam_apb_regs import cam_pkg::*; (
  input  logic                   ccd_pixel_clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [apb_addr_w-1:0]  paddr,
  input  logic [apb_data_w-1:0]  pwdata,
  output logic [apb_data_w-1:0]  prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic [frame_cnt_w-1:0] frame_count,  // Live count from capture
  cfg_if.regs                    cfg
);

  logic                  access;     // Access phase
  logic                  mapped;     // Address hits the map
  logic                  ro_hit;     // Write to read-only count
  logic                  wr_en;
  logic [apb_data_w-1:0] ctrl_word;

  assign access = psel & penable;
  assign pready = 1'b1;  // Zero wait states

  // Address decode
  always_comb begin
    case (paddr)
      addr_ctrl, addr_width, addr_height, addr_thresh, addr_frames: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign ro_hit  = pwrite & (paddr == addr_frames);
  assign wr_en   = access & pwrite & mapped & !ro_hit;
  assign pslverr = access & (!mapped | ro_hit);

  // ==================================================
  // Register writes at the access-phase edge
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      cfg.start       <= ctrl_rst[ctrl_start_bit];
      cfg.binary_mode <= ctrl_rst[ctrl_bin_bit];
      cfg.red_en      <= ctrl_rst[ctrl_red_bit];
      cfg.green_en    <= ctrl_rst[ctrl_green_bit];
      cfg.blue_en     <= ctrl_rst[ctrl_blue_bit];
      cfg.width       <= width_rst;
      cfg.height      <= height_rst;
      cfg.threshold   <= thresh_rst;
    end else if (wr_en) begin
      case (paddr)
        addr_ctrl: begin
          cfg.start       <= pwdata[ctrl_start_bit];
          cfg.binary_mode <= pwdata[ctrl_bin_bit];
          cfg.red_en      <= pwdata[ctrl_red_bit];
          cfg.green_en    <= pwdata[ctrl_green_bit];
          cfg.blue_en     <= pwdata[ctrl_blue_bit];
        end
        addr_width:  cfg.width     <= pwdata[coord_w-1:0];
        addr_height: cfg.height    <= pwdata[coord_w-1:0];
        addr_thresh: cfg.threshold <= pwdata[bin_w-1:0];
        default: ;  // Frame count is read only
      endcase
    end
  end

  // Control bits packed back for readback
  always_comb begin
    ctrl_word                 = '0;
    ctrl_word[ctrl_start_bit] = cfg.start;
    ctrl_word[ctrl_bin_bit]   = cfg.binary_mode;
    ctrl_word[ctrl_red_bit]   = cfg.red_en;
    ctrl_word[ctrl_green_bit] = cfg.green_en;
    ctrl_word[ctrl_blue_bit]  = cfg.blue_en;
  end

  // Read mux, valid through setup and access
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        addr_ctrl:   prdata = ctrl_word;
        addr_width:  prdata = apb_data_w'(cfg.width);
        addr_height: prdata = apb_data_w'(cfg.height);
        addr_thresh: prdata = apb_data_w'(cfg.threshold);
        addr_frames: prdata = apb_data_w'(frame_count);
        default:     prdata = '0;
      endcase
    end
  end

endmodule

/* logic/camera_capture.sv */
// Camera pin registers, column/row counters, window gate, frame start/stop, frame counter
`timescale 1ns/1ns

module camera_capture import cam_pkg::*; (
  input  logic                   ccd_pixel_clk,
  input  logic                   reset,
  input  raw_t                   ccd_data,
  input  logic                   ccd_fval,
  input  logic                   ccd_lval,
  cfg_if.usr                     cfg,
  pixel_if.src                   pix,
  output logic [frame_cnt_w-1:0] frame_count
);

  raw_t   data_q;     // Sampled pins
  logic   fval_q;
  logic   lval_q;
  logic   fval_d;     // One cycle later, for edges
  logic   lval_d;
  logic   fval_rise;
  logic   fval_fall;
  logic   lval_rise;
  logic   lval_fall;
  coord_t col_cnt;    // Column of next pixel
  coord_t row_cnt;    // Row of next line
  coord_t col_now;    // Column of the sampled pixel
  coord_t row_now;
  logic   active;     // Capturing current frame
  logic   act_now;
  logic   in_window;

  // ==================================================
  // Pin sampling
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;  // Payload only
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_q <= ccd_fval;
      lval_q <= ccd_lval;
      fval_d <= fval_q;
      lval_d <= lval_q;
    end
  end

  assign fval_rise = fval_q & !fval_d;
  assign fval_fall = !fval_q & fval_d;
  assign lval_rise = lval_q & !lval_d;
  assign lval_fall = !lval_q & lval_d;

  // Counters restart on the rising edge of their valid
  assign col_now = lval_rise ? '0 : col_cnt;
  assign row_now = fval_rise ? '0 : row_cnt;
  assign act_now = fval_rise ? cfg.start : active;  // Start only on frame boundary

  assign in_window = act_now & lval_q & (col_now < cfg.width) & (row_now < cfg.height);

  // ==================================================
  // Counters, start/stop, frame count
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      col_cnt     <= '0;
      row_cnt     <= '0;
      active      <= 1'b0;
      frame_count <= '0;
    end else begin
      if (lval_q) col_cnt <= col_now + coord_t'(1);
      row_cnt <= lval_fall ? row_now + coord_t'(1) : row_now;  // Next line
      if (fval_rise) begin
        active <= cfg.start;
      end else if (fval_fall && !cfg.start) begin
        active <= 1'b0;  // Stop after frame ends
      end
      if (fval_fall && active) frame_count <= frame_count + 1'b1;
    end
  end

  // Output stage, one cycle after sampling
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) pix.valid <= 1'b0;
    else       pix.valid <= in_window;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    pix.data <= data_q;
    pix.col  <= col_now;
    pix.row  <= row_now;
  end

endmodule

/* logic/pixel_pack.sv */
// Raw sample to frame word, 5-5-5 colour or binarized byte
`timescale 1ns/1ns

module pixel_pack import cam_pkg::*; (
  input  logic ccd_pixel_clk,
  input  logic reset,
  cfg_if.usr   cfg,
  pixel_if.snk in_pix,   // raw_t data
  pixel_if.src out_pix   // frame_word_t data
);

  frame_word_t word;
  logic        bright;   // Upper byte at or above threshold

  assign bright = in_pix.data[raw_w-1 -: bin_w] >= cfg.threshold;

  // ==================================================
  // Word build
  // ==================================================
  always_comb begin
    word = '0;  // Pad and upper byte stay zero
    if (cfg.binary_mode) begin
      word.bin.value = bright ? '1 : '0;
    end else begin
      // Monochrome sample fills all three fields
      word.rgb.red   = in_pix.data[raw_w-1 -: field_w];
      word.rgb.green = in_pix.data[raw_w-1 -: field_w];
      word.rgb.blue  = in_pix.data[raw_w-1 -: field_w];
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) out_pix.valid <= 1'b0;
    else       out_pix.valid <= in_pix.valid;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    out_pix.data <= word;
    out_pix.col  <= in_pix.col;  // Position travels with the pixel
    out_pix.row  <= in_pix.row;
  end

endmodule

/* logic/video_out.sv */
// Frame word decode to 8-bit red, green, blue with channel enables
`timescale 1ns/1ns

module video_out import cam_pkg::*; (
  input  logic  ccd_pixel_clk,
  input  logic  reset,
  cfg_if.usr    cfg,
  pixel_if.snk  pix,        // frame_word_t data
  output logic  out_valid,
  output chan_t out_red,
  output chan_t out_green,
  output chan_t out_blue
);

  localparam int pad_w = chan_w - field_w;  // Zero fill below a field

  chan_t red_d;
  chan_t green_d;
  chan_t blue_d;

  // ==================================================
  // Decode by mode
  // ==================================================
  always_comb begin
    red_d   = '0;
    green_d = '0;
    blue_d  = '0;
    if (pix.valid) begin
      if (cfg.binary_mode) begin
        red_d   = pix.data.bin.value;  // Grey binary on all channels
        green_d = pix.data.bin.value;
        blue_d  = pix.data.bin.value;
      end else begin
        if (cfg.red_en)   red_d   = {pix.data.rgb.red, {pad_w{1'b0}}};
        if (cfg.green_en) green_d = {pix.data.rgb.green, {pad_w{1'b0}}};
        if (cfg.blue_en)  blue_d  = {pix.data.rgb.blue, {pad_w{1'b0}}};
      end
    end
  end

  // Registered outputs, zero when idle
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_red   <= '0;
      out_green <= '0;
      out_blue  <= '0;
    end else begin
      out_valid <= pix.valid;
      out_red   <= red_d;
      out_green <= green_d;
      out_blue  <= blue_d;
    end
  end

endmodule

/* logic/cam_top.sv */
// Top level with camera, APB and video ports, wiring registers and pixel path
`timescale 1ns/1ns

module cam_top import cam_pkg::*; (
  input  logic                  ccd_pixel_clk,
  input  logic                  reset,
  // Camera pins
  input  raw_t                  ccd_data,
  input  logic                  ccd_fval,
  input  logic                  ccd_lval,
  // APB slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Video stream
  output logic                  out_valid,
  output chan_t                 out_red,
  output chan_t                 out_green,
  output chan_t                 out_blue
);

  logic [frame_cnt_w-1:0] frame_count;

  cfg_if                             cfg_bus ();
  pixel_if #(.data_t(raw_t))        cap_pix ();     // Windowed raw samples
  pixel_if #(.data_t(frame_word_t)) packed_pix ();  // Frame words

  // ==================================================
  // Blocks
  // ==================================================
  cam_apb_regs regs_i (
    .ccd_pixel_clk(ccd_pixel_clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .frame_count(frame_count), .cfg(cfg_bus)
  );

  camera_capture capture_i (
    .ccd_pixel_clk(ccd_pixel_clk), .reset(reset),
    .ccd_data(ccd_data), .ccd_fval(ccd_fval), .ccd_lval(ccd_lval),
    .cfg(cfg_bus), .pix(cap_pix), .frame_count(frame_count)
  );

  pixel_pack pack_i (
    .ccd_pixel_clk(ccd_pixel_clk), .reset(reset),
    .cfg(cfg_bus), .in_pix(cap_pix), .out_pix(packed_pix)
  );

  video_out video_i (
    .ccd_pixel_clk(ccd_pixel_clk), .reset(reset), .cfg(cfg_bus), .pix(packed_pix),
    .out_valid(out_valid), .out_red(out_red), .out_green(out_green), .out_blue(out_blue)
  );

endmodule

/* dv/cam_asserts.sv */
// Concurrent checks on APB ready, output latency and idle outputs, bound to cam_top
`timescale 1ns/1ns

module cam_asserts import cam_pkg::*; (
  input logic  ccd_pixel_clk,
  input logic  reset,
  input logic  pready,
  input logic  ccd_lval,
  input logic  out_valid,
  input chan_t out_red,
  input chan_t out_green,
  input chan_t out_blue
);

  int fail_count = 0;  // Failed assertions so far

  // ==================================================
  // APB
  // ==================================================
  apb_ready: assert property (@(posedge ccd_pixel_clk) disable iff (reset) pready)
    else begin
      fail_count++;
      $error("pready dropped low");
    end

  // ==================================================
  // Output stream
  // ==================================================
  out_latency: assert property (@(posedge ccd_pixel_clk) disable iff (reset)
    out_valid |-> $past(ccd_lval, 4))  // Pin pixel four edges back
    else begin
      fail_count++;
      $error("out_valid without a pin pixel four cycles earlier");
    end

  out_idle_zero: assert property (@(posedge ccd_pixel_clk) disable iff (reset)
    !out_valid |-> (out_red == '0 && out_green == '0 && out_blue == '0))
    else begin
      fail_count++;
      $error("colour outputs not zero while out_valid is low");
    end

endmodule

bind cam_top cam_asserts asserts_i (
  .ccd_pixel_clk(ccd_pixel_clk), .reset(reset),
  .pready(pready), .ccd_lval(ccd_lval), .out_valid(out_valid),
  .out_red(out_red), .out_green(out_green), .out_blue(out_blue)
);

/* dv/cam_tb.sv */
// Testbench for cam_top: clock, reset, APB and camera drivers, stim reader, model, compare tasks
`timescale 1ns/1ns

module cam_tb import cam_pkg::*; ();

  localparam int drive_delay   = 1;    // After the rising edge
  localparam int apb_timeout   = 16;   // Cycles waiting for pready
  localparam int drain_timeout = 200;  // Cycles waiting for queued pixels

  logic                  ccd_pixel_clk;
  logic                  reset;
  raw_t                  ccd_data;
  logic                  ccd_fval;
  logic                  ccd_lval;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata;
  logic [apb_data_w-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  out_valid;
  chan_t                 out_red;
  chan_t                 out_green;
  chan_t                 out_blue;

  int    value_errs;
  int    other_errs;
  // Reference model state, mirrors register writes
  logic  m_start;
  logic  m_bin;
  logic  m_red_en;
  logic  m_green_en;
  logic  m_blue_en;
  int    m_width;
  int    m_height;
  int    m_thresh;
  chan_t exp_red[$];  // Expected pixels in order
  chan_t exp_green[$];
  chan_t exp_blue[$];

  cam_top dut_i (.*);

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #2 ccd_pixel_clk = ~ccd_pixel_clk;  // 4 ns period
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_chan(input string name, input chan_t got, input chan_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [apb_data_w-1:0] got,
                            input logic [apb_data_w-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ==================================================
  // APB and camera drivers
  // ==================================================
  task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                          input logic [apb_data_w-1:0] wdata,
                          output logic [apb_data_w-1:0] rdata, output logic err);
    int n;
    @(posedge ccd_pixel_clk) #drive_delay;
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge ccd_pixel_clk) #drive_delay;
    penable = 1'b1;  // Access phase
    @(negedge ccd_pixel_clk);
    n = 0;
    while (pready !== 1'b1 && n < apb_timeout) begin
      @(negedge ccd_pixel_clk);
      n++;
    end
    if (n == apb_timeout) begin
      other_errs++;
      $display("APB transfer to %h got no pready in %0d cycles", addr, apb_timeout);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge ccd_pixel_clk) #drive_delay;  // Write lands on this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic model_write(input logic [apb_addr_w-1:0] addr,
                             input logic [apb_data_w-1:0] data);
    case (addr)
      addr_ctrl: begin
        m_start    = data[0];
        m_bin      = data[1];
        m_red_en   = data[4];
        m_green_en = data[5];
        m_blue_en  = data[6];
      end
      addr_width:  m_width  = int'(data[11:0]);
      addr_height: m_height = int'(data[11:0]);
      addr_thresh: m_thresh = int'(data[7:0]);
      default: ;
    endcase
  endtask

  // Expected channels for one captured sample
  task automatic model_pixel(input raw_t raw);
    chan_t field;
    chan_t level;
    field = {raw[11:7], 3'b000};
    level = (int'(raw[11:4]) >= m_thresh) ? 8'hFF : 8'h00;
    exp_red.push_back(m_bin ? level : (m_red_en ? field : 8'h00));
    exp_green.push_back(m_bin ? level : (m_green_en ? field : 8'h00));
    exp_blue.push_back(m_bin ? level : (m_blue_en ? field : 8'h00));
  endtask

  task automatic drive_frame(input int lines, input int pixels, input int blank);
    raw_t raw;
    logic captured;
    captured = m_start;  // Start only counts at the frame edge
    @(posedge ccd_pixel_clk) #drive_delay;
    ccd_fval = 1'b1;
    for (int r = 0; r < lines; r++) begin
      for (int c = 0; c < pixels; c++) begin
        @(posedge ccd_pixel_clk) #drive_delay;
        raw      = raw_t'($urandom);
        ccd_lval = 1'b1;
        ccd_data = raw;
        if (captured && c < m_width && r < m_height) model_pixel(raw);
      end
      repeat (blank) begin
        @(posedge ccd_pixel_clk) #drive_delay;
        ccd_lval = 1'b0;  // Line blanking
        ccd_data = '0;
      end
    end
    @(posedge ccd_pixel_clk) #drive_delay;
    ccd_fval = 1'b0;
    repeat (blank) @(posedge ccd_pixel_clk);
  endtask

  task automatic drain_outputs();
    int n;
    n = 0;
    while (exp_red.size() > 0 && n < drain_timeout) begin
      @(negedge ccd_pixel_clk);
      n++;
    end
    if (exp_red.size() > 0) begin
      other_errs++;
      $display("Timeout with %0d expected pixels never seen on the output", exp_red.size());
      exp_red.delete();
      exp_green.delete();
      exp_blue.delete();
    end
  endtask

  // Output stream checker, samples between edges
  initial begin : stream_monitor
    forever begin
      @(negedge ccd_pixel_clk);
      if (reset === 1'b0 && out_valid === 1'b1) begin
        if (exp_red.size() == 0) begin
          other_errs++;
          $display("Pixel on the output at %0t ns that no frame should produce", $time);
        end else begin
          check_chan("out_red", out_red, exp_red.pop_front());
          check_chan("out_green", out_green, exp_green.pop_front());
          check_chan("out_blue", out_blue, exp_blue.pop_front());
        end
      end
    end
  end

  // ==================================================
  // Stimulus file sequence
  // ==================================================
  initial begin : main_flow
    int                    fd;
    int                    code;
    string                 line;
    byte                   kind;
    logic [apb_addr_w-1:0] addr;
    logic [apb_data_w-1:0] data;
    logic [apb_data_w-1:0] rdata;
    logic                  exp_err;
    logic                  err;
    int                    lines;
    int                    pixels;
    int                    blank;
    int                    assert_fails;
    value_errs = 0;
    other_errs = 0;
    void'($urandom(63432));
    reset    = 1'b1;
    ccd_data = '0;
    ccd_fval = 1'b0;
    ccd_lval = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    model_write(addr_ctrl, '0);  // Model starts at reset values
    m_width  = 640;
    m_height = 480;
    m_thresh = 60;
    repeat (3) @(posedge ccd_pixel_clk);
    #drive_delay reset = 1'b0;
    fd = $fopen("dv/cam_stim.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Stimulus file dv/cam_stim.txt could not be opened");
    end else begin
      while ($fgets(line, fd) > 0) begin
        code = $sscanf(line, "%c", kind);
        if (kind == "W") begin
          code = $sscanf(line, "W %h %h %h", addr, data, exp_err);
          apb_xfer(1'b1, addr, data, rdata, err);
          check_flag("pslverr", err, exp_err);
          if (!exp_err) model_write(addr, data);
        end else if (kind == "R") begin
          code = $sscanf(line, "R %h %h %h", addr, data, exp_err);
          apb_xfer(1'b0, addr, '0, rdata, err);
          check_word("prdata", rdata, data);
          check_flag("pslverr", err, exp_err);
        end else if (kind == "F") begin
          code = $sscanf(line, "F %d %d %d", lines, pixels, blank);
          drive_frame(lines, pixels, blank);
          drain_outputs();
        end else if (kind != "#" && kind != "\n") begin
          other_errs++;
          $display("Stimulus line not understood: %s", line);
        end
      end
      $fclose(fd);
    end
    repeat (8) @(posedge ccd_pixel_clk);  // Catch stray outputs
    assert_fails = dut_i.asserts_i.fail_count;
    $display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             assert_fails);
    if (value_errs + other_errs + assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/cam_stim.txt */
# W addr data err: APB write, expected pslverr | R addr data err: APB read, expected prdata, pslverr
# F lines pixels blank: camera frame, blank cycles after each line and after the frame
R 00 00000000 0
R 04 00000280 0
R 08 000001E0 0
R 0C 0000003C 0
R 10 00000000 0
R 14 00000000 1
W 10 00000005 1
W 04 00000006 0
W 08 00000004 0
W 0C 00000080 0
R 04 00000006 0
R 08 00000004 0
R 0C 00000080 0
F 3 5 3
W 00 00000071 0
R 00 00000071 0
F 5 8 3
F 3 4 2
W 00 00000051 0
F 4 7 2
W 00 00000003 0
F 4 6 2
W 00 00000000 0
F 3 5 2
R 10 00000004 0

/* flist.f */
logic/cam_pkg.sv
logic/cam_ifs.sv
logic/cam_apb_regs.sv
logic/camera_capture.sv
logic/pixel_pack.sv
logic/video_out.sv
logic/cam_top.sv
dv/cam_asserts.sv
dv/cam_tb.sv

/* Makefile */
# Verilator build and run for the camera pixel path testbench

VERILATOR ?= verilator
TOP       ?= cam_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
